// File: common/pcie_fifo_pkg.sv
package pcie_fifo_pkg;

  // One 32-bit link word
  typedef logic [31:0] word_t;

  // One stream beat
  // valid and ready travel beside it
  typedef struct packed {
    word_t data;
    logic  last;
  } axis_beat_t;

  // Function number bit that picks the channel
  localparam logic CMD_FUNCTION_ID  = 1'b0;
  localparam logic DATA_FUNCTION_ID = 1'b1;

  // Bank address widths
  // 32 words per command bank
  localparam int CMD_ADDR_W  = 5;
  // 128 words per data bank
  localparam int DATA_ADDR_W = 7;

  // Width of a bank word count
  localparam int COUNT_W = 24;

endpackage

// File: ppfifo/ppfifo.sv
`timescale 1ns/1ps

module ppfifo #(
  parameter int ADDR_W = 5
) (
  input  logic                              i_clk,
  input  logic                              i_reset,
  // Bank write side
  input  logic [1:0]                        i_wr_activate,
  input  logic                              i_wr_stb,
  input  pcie_fifo_pkg::word_t              i_wr_data,
  output logic [1:0]                        o_wr_ready,
  // Bank read side
  input  logic                              i_rd_activate,
  input  logic                              i_rd_stb,
  output logic                              o_rd_ready,
  output logic [pcie_fifo_pkg::COUNT_W-1:0] o_rd_count,
  output pcie_fifo_pkg::word_t              o_rd_data
);

  pcie_fifo_pkg::word_t mem [2][2**ADDR_W];

  logic [pcie_fifo_pkg::COUNT_W-1:0] bank_count [2];
  logic [1:0]                        bank_full;
  logic [1:0]                        wr_act_q;
  logic                              rd_act_q;
  logic                              rd_next;
  logic                              wr_bank;
  logic [1:0]                        wr_release;
  logic                              rd_release;
  logic [ADDR_W-1:0]                 wr_addr;
  logic [ADDR_W-1:0]                 rd_addr;

  // Only one write bank is active at a time
  assign wr_bank    = i_wr_activate[1];
  assign wr_release = wr_act_q & ~i_wr_activate;
  assign rd_release = rd_act_q & ~i_rd_activate;

  // Writable while empty and not claimed
  assign o_wr_ready = ~bank_full & ~wr_act_q & ~i_wr_activate;

  // The oldest filled bank is offered to the reader
  assign o_rd_ready = bank_full[rd_next] & ~rd_act_q & ~i_rd_activate;
  assign o_rd_count = bank_count[rd_next];
  // First word falls through
  assign o_rd_data  = mem[rd_next][rd_addr];

  always_ff @(posedge i_clk) begin
    if (i_wr_stb && (|i_wr_activate)) begin
      mem[wr_bank][wr_addr] <= i_wr_data;
    end
  end

  // Addresses restart whenever a side lets go of its bank
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_addr <= '0;
      rd_addr <= '0;
    end else begin
      if (!(|i_wr_activate)) begin
        wr_addr <= '0;
      end else if (i_wr_stb) begin
        wr_addr <= wr_addr + 1'b1;
      end
      if (!i_rd_activate) begin
        rd_addr <= '0;
      end else if (i_rd_stb) begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  // Bank hand-over between writer and reader
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      bank_full  <= '0;
      bank_count <= '{default: '0};
      wr_act_q   <= '0;
      rd_act_q   <= 1'b0;
      rd_next    <= 1'b0;
    end else begin
      wr_act_q <= i_wr_activate;
      rd_act_q <= i_rd_activate;
      for (int b = 0; b < 2; b++) begin
        if (i_wr_stb && i_wr_activate[b]) begin
          bank_count[b] <= bank_count[b] + 1'b1;
        end
        // A bank released with no words stays writable
        if (wr_release[b] && (bank_count[b] != '0)) begin
          bank_full[b] <= 1'b1;
          // Nothing older is waiting, so read this one next
          if (!bank_full[1-b]) begin
            rd_next <= b[0];
          end
        end
      end
      if (rd_release) begin
        bank_full[rd_next]  <= 1'b0;
        bank_count[rd_next] <= '0;
        rd_next             <= ~rd_next;
      end
    end
  end

endmodule

// File: verilog/axis_to_ppfifo.sv
`timescale 1ns/1ps

module axis_to_ppfifo #(
  parameter int ADDR_W = 5
) (
  input  logic                      i_clk,
  input  logic                      i_reset,
  // Incoming stream
  input  logic                      i_valid,
  input  pcie_fifo_pkg::axis_beat_t i_beat,
  output logic                      o_ready,
  // Bank write side
  input  logic [1:0]                i_wr_ready,
  output logic [1:0]                o_wr_activate,
  output logic                      o_wr_stb,
  output pcie_fifo_pkg::word_t      o_wr_data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_RELEASE
  } state_t;

  state_t            state;
  logic [ADDR_W-1:0] word_cnt;
  logic              accept;

  assign o_ready = (state == ST_WRITE);
  assign accept  = i_valid & o_ready;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state         <= ST_IDLE;
      o_wr_activate <= '0;
      o_wr_stb      <= 1'b0;
      word_cnt      <= '0;
    end else begin
      o_wr_stb <= accept;
      case (state)
        ST_IDLE: begin
          // Claim a free bank, bank 0 first
          if (|i_wr_ready) begin
            o_wr_activate <= i_wr_ready[0] ? 2'b01 : 2'b10;
            word_cnt      <= '0;
            state         <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          if (accept) begin
            word_cnt <= word_cnt + 1'b1;
            // Close on packet end or on the bank's final slot
            if (i_beat.last || (word_cnt == '1)) begin
              state <= ST_RELEASE;
            end
          end
        end
        default: begin
          // Registered strobe lands before the bank is let go
          o_wr_activate <= '0;
          state         <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_wr_data <= i_beat.data;
    end
  end

endmodule

// File: verilog/ppfifo_to_axis.sv
`timescale 1ns/1ps

module ppfifo_to_axis #(
  parameter int ADDR_W = 5
) (
  input  logic                              i_clk,
  input  logic                              i_reset,
  // Bank read side
  input  logic                              i_rd_ready,
  input  logic [pcie_fifo_pkg::COUNT_W-1:0] i_rd_count,
  input  pcie_fifo_pkg::word_t              i_rd_data,
  output logic                              o_rd_activate,
  output logic                              o_rd_stb,
  // Outgoing stream
  output logic                              o_valid,
  output pcie_fifo_pkg::axis_beat_t         o_beat,
  input  logic                              i_ready
);

  // Words left in the bank after the current one
  logic [ADDR_W-1:0] remain;
  logic              accept;

  // Data stays put until a strobe, so valid can track the claim
  assign o_valid     = o_rd_activate;
  assign o_beat.data = i_rd_data;
  assign o_beat.last = (remain == '0);
  assign accept      = o_valid & i_ready;

  // Pop only on an accepted beat
  assign o_rd_stb = accept;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_rd_activate <= 1'b0;
      remain        <= '0;
    end else begin
      if (!o_rd_activate) begin
        if (i_rd_ready) begin
          o_rd_activate <= 1'b1;
          // A full bank wraps to zero and still gives the right value
          remain        <= i_rd_count[ADDR_W-1:0] - 1'b1;
        end
      end else if (accept) begin
        remain <= remain - 1'b1;
        if (o_beat.last) begin
          o_rd_activate <= 1'b0;
        end
      end
    end
  end

endmodule

// File: verilog/function_steer.sv
`timescale 1ns/1ps

module function_steer (
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic                      i_function_number,
  // Link rx stream
  input  logic                      i_rx_valid,
  input  pcie_fifo_pkg::axis_beat_t i_rx_beat,
  output logic                      o_rx_ready,
  // Channel rx streams
  output logic                      o_cmd_rx_valid,
  output logic                      o_data_rx_valid,
  output pcie_fifo_pkg::axis_beat_t o_chan_rx_beat,
  input  logic                      i_cmd_rx_ready,
  input  logic                      i_data_rx_ready,
  // Channel tx streams
  input  logic                      i_cmd_tx_valid,
  input  pcie_fifo_pkg::axis_beat_t i_cmd_tx_beat,
  output logic                      o_cmd_tx_ready,
  input  logic                      i_data_tx_valid,
  input  pcie_fifo_pkg::axis_beat_t i_data_tx_beat,
  output logic                      o_data_tx_ready,
  // Link tx stream
  output logic                      o_tx_valid,
  output pcie_fifo_pkg::axis_beat_t o_tx_beat,
  input  logic                      i_tx_ready
);

  logic sel;
  logic sel_cmd;
  logic sel_data;
  logic rx_in_pkt;
  logic tx_in_pkt;
  logic rx_fire;
  logic tx_fire;

  assign sel_cmd  = (sel == pcie_fifo_pkg::CMD_FUNCTION_ID);
  assign sel_data = (sel == pcie_fifo_pkg::DATA_FUNCTION_ID);

  // Unselected channel sees no valid and no ready
  assign o_cmd_rx_valid  = i_rx_valid & sel_cmd;
  assign o_data_rx_valid = i_rx_valid & sel_data;
  assign o_chan_rx_beat  = i_rx_beat;
  assign o_rx_ready      = sel_cmd ? i_cmd_rx_ready : i_data_rx_ready;

  assign o_tx_valid      = sel_cmd ? i_cmd_tx_valid : i_data_tx_valid;
  assign o_tx_beat       = sel_cmd ? i_cmd_tx_beat : i_data_tx_beat;
  assign o_cmd_tx_ready  = i_tx_ready & sel_cmd;
  assign o_data_tx_ready = i_tx_ready & sel_data;

  assign rx_fire = i_rx_valid & o_rx_ready;
  assign tx_fire = o_tx_valid & i_tx_ready;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      sel       <= pcie_fifo_pkg::CMD_FUNCTION_ID;
      rx_in_pkt <= 1'b0;
      tx_in_pkt <= 1'b0;
    end else begin
      if (rx_fire) begin
        rx_in_pkt <= ~i_rx_beat.last;
      end
      if (tx_fire) begin
        tx_in_pkt <= ~o_tx_beat.last;
      end
      // Switch only in a gap with no beat moving either way
      if (!rx_in_pkt && !tx_in_pkt && !rx_fire && !tx_fire) begin
        sel <= i_function_number;
      end
    end
  end

endmodule

// File: verilog/pcie_fifo_top.sv
`timescale 1ns/1ps

module pcie_fifo_top (
  input  logic                              i_clk,
  input  logic                              i_reset,
  input  logic                              i_function_number,
  // Link streams
  input  logic                              i_rx_valid,
  input  pcie_fifo_pkg::axis_beat_t         i_rx_beat,
  output logic                              o_rx_ready,
  output logic                              o_tx_valid,
  output pcie_fifo_pkg::axis_beat_t         o_tx_beat,
  input  logic                              i_tx_ready,
  // Command channel
  output logic                              o_cmd_in_rd_ready,
  input  logic                              i_cmd_in_rd_activate,
  input  logic                              i_cmd_in_rd_stb,
  output logic [pcie_fifo_pkg::COUNT_W-1:0] o_cmd_in_rd_count,
  output pcie_fifo_pkg::word_t              o_cmd_in_rd_data,
  output logic [1:0]                        o_cmd_out_wr_ready,
  input  logic [1:0]                        i_cmd_out_wr_activate,
  input  logic                              i_cmd_out_wr_stb,
  input  pcie_fifo_pkg::word_t              i_cmd_out_wr_data,
  // Data channel
  output logic                              o_data_in_rd_ready,
  input  logic                              i_data_in_rd_activate,
  input  logic                              i_data_in_rd_stb,
  output logic [pcie_fifo_pkg::COUNT_W-1:0] o_data_in_rd_count,
  output pcie_fifo_pkg::word_t              o_data_in_rd_data,
  output logic [1:0]                        o_data_out_wr_ready,
  input  logic [1:0]                        i_data_out_wr_activate,
  input  logic                              i_data_out_wr_stb,
  input  pcie_fifo_pkg::word_t              i_data_out_wr_data
);

  // Steer to channel streams
  logic                              cmd_rx_valid;
  logic                              data_rx_valid;
  pcie_fifo_pkg::axis_beat_t         chan_rx_beat;
  logic                              cmd_rx_ready;
  logic                              data_rx_ready;
  logic                              cmd_tx_valid;
  pcie_fifo_pkg::axis_beat_t         cmd_tx_beat;
  logic                              cmd_tx_ready;
  logic                              data_tx_valid;
  pcie_fifo_pkg::axis_beat_t         data_tx_beat;
  logic                              data_tx_ready;

  // Ingress bank write sides
  logic [1:0]                        cmd_in_wr_ready;
  logic [1:0]                        cmd_in_wr_activate;
  logic                              cmd_in_wr_stb;
  pcie_fifo_pkg::word_t              cmd_in_wr_data;
  logic [1:0]                        data_in_wr_ready;
  logic [1:0]                        data_in_wr_activate;
  logic                              data_in_wr_stb;
  pcie_fifo_pkg::word_t              data_in_wr_data;

  // Egress bank read sides
  logic                              cmd_out_rd_ready;
  logic                              cmd_out_rd_activate;
  logic                              cmd_out_rd_stb;
  logic [pcie_fifo_pkg::COUNT_W-1:0] cmd_out_rd_count;
  pcie_fifo_pkg::word_t              cmd_out_rd_data;
  logic                              data_out_rd_ready;
  logic                              data_out_rd_activate;
  logic                              data_out_rd_stb;
  logic [pcie_fifo_pkg::COUNT_W-1:0] data_out_rd_count;
  pcie_fifo_pkg::word_t              data_out_rd_data;

  function_steer u_steer (
    .i_clk(i_clk), .i_reset(i_reset), .i_function_number(i_function_number),
    .i_rx_valid(i_rx_valid), .i_rx_beat(i_rx_beat), .o_rx_ready(o_rx_ready),
    .o_cmd_rx_valid(cmd_rx_valid), .o_data_rx_valid(data_rx_valid),
    .o_chan_rx_beat(chan_rx_beat),
    .i_cmd_rx_ready(cmd_rx_ready), .i_data_rx_ready(data_rx_ready),
    .i_cmd_tx_valid(cmd_tx_valid), .i_cmd_tx_beat(cmd_tx_beat),
    .o_cmd_tx_ready(cmd_tx_ready),
    .i_data_tx_valid(data_tx_valid), .i_data_tx_beat(data_tx_beat),
    .o_data_tx_ready(data_tx_ready),
    .o_tx_valid(o_tx_valid), .o_tx_beat(o_tx_beat), .i_tx_ready(i_tx_ready)
  );

  // Command channel
  axis_to_ppfifo #(.ADDR_W(pcie_fifo_pkg::CMD_ADDR_W)) u_cmd_a2p (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_valid(cmd_rx_valid), .i_beat(chan_rx_beat), .o_ready(cmd_rx_ready),
    .i_wr_ready(cmd_in_wr_ready), .o_wr_activate(cmd_in_wr_activate),
    .o_wr_stb(cmd_in_wr_stb), .o_wr_data(cmd_in_wr_data)
  );

  ppfifo #(.ADDR_W(pcie_fifo_pkg::CMD_ADDR_W)) u_cmd_ingress (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_wr_activate(cmd_in_wr_activate), .i_wr_stb(cmd_in_wr_stb),
    .i_wr_data(cmd_in_wr_data), .o_wr_ready(cmd_in_wr_ready),
    .i_rd_activate(i_cmd_in_rd_activate), .i_rd_stb(i_cmd_in_rd_stb),
    .o_rd_ready(o_cmd_in_rd_ready), .o_rd_count(o_cmd_in_rd_count),
    .o_rd_data(o_cmd_in_rd_data)
  );

  ppfifo #(.ADDR_W(pcie_fifo_pkg::CMD_ADDR_W)) u_cmd_egress (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_wr_activate(i_cmd_out_wr_activate), .i_wr_stb(i_cmd_out_wr_stb),
    .i_wr_data(i_cmd_out_wr_data), .o_wr_ready(o_cmd_out_wr_ready),
    .i_rd_activate(cmd_out_rd_activate), .i_rd_stb(cmd_out_rd_stb),
    .o_rd_ready(cmd_out_rd_ready), .o_rd_count(cmd_out_rd_count),
    .o_rd_data(cmd_out_rd_data)
  );

  ppfifo_to_axis #(.ADDR_W(pcie_fifo_pkg::CMD_ADDR_W)) u_cmd_p2a (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_rd_ready(cmd_out_rd_ready), .i_rd_count(cmd_out_rd_count),
    .i_rd_data(cmd_out_rd_data), .o_rd_activate(cmd_out_rd_activate),
    .o_rd_stb(cmd_out_rd_stb),
    .o_valid(cmd_tx_valid), .o_beat(cmd_tx_beat), .i_ready(cmd_tx_ready)
  );

  // Data channel
  axis_to_ppfifo #(.ADDR_W(pcie_fifo_pkg::DATA_ADDR_W)) u_data_a2p (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_valid(data_rx_valid), .i_beat(chan_rx_beat), .o_ready(data_rx_ready),
    .i_wr_ready(data_in_wr_ready), .o_wr_activate(data_in_wr_activate),
    .o_wr_stb(data_in_wr_stb), .o_wr_data(data_in_wr_data)
  );

  ppfifo #(.ADDR_W(pcie_fifo_pkg::DATA_ADDR_W)) u_data_ingress (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_wr_activate(data_in_wr_activate), .i_wr_stb(data_in_wr_stb),
    .i_wr_data(data_in_wr_data), .o_wr_ready(data_in_wr_ready),
    .i_rd_activate(i_data_in_rd_activate), .i_rd_stb(i_data_in_rd_stb),
    .o_rd_ready(o_data_in_rd_ready), .o_rd_count(o_data_in_rd_count),
    .o_rd_data(o_data_in_rd_data)
  );

  ppfifo #(.ADDR_W(pcie_fifo_pkg::DATA_ADDR_W)) u_data_egress (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_wr_activate(i_data_out_wr_activate), .i_wr_stb(i_data_out_wr_stb),
    .i_wr_data(i_data_out_wr_data), .o_wr_ready(o_data_out_wr_ready),
    .i_rd_activate(data_out_rd_activate), .i_rd_stb(data_out_rd_stb),
    .o_rd_ready(data_out_rd_ready), .o_rd_count(data_out_rd_count),
    .o_rd_data(data_out_rd_data)
  );

  ppfifo_to_axis #(.ADDR_W(pcie_fifo_pkg::DATA_ADDR_W)) u_data_p2a (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_rd_ready(data_out_rd_ready), .i_rd_count(data_out_rd_count),
    .i_rd_data(data_out_rd_data), .o_rd_activate(data_out_rd_activate),
    .o_rd_stb(data_out_rd_stb),
    .o_valid(data_tx_valid), .o_beat(data_tx_beat), .i_ready(data_tx_ready)
  );

endmodule

// File: tb/pcie_fifo_assert.sv
`timescale 1ns/1ps

module pcie_fifo_assert (
  input logic                      i_clk,
  input logic                      i_reset,
  input logic                      i_rx_valid,
  input logic                      o_rx_ready,
  input pcie_fifo_pkg::axis_beat_t i_rx_beat,
  input logic                      o_tx_valid,
  input logic                      i_tx_ready,
  input pcie_fifo_pkg::axis_beat_t o_tx_beat,
  input logic [1:0]                o_cmd_out_wr_ready,
  input logic [1:0]                o_data_out_wr_ready,
  input logic                      o_cmd_in_rd_ready,
  input logic                      i_cmd_in_rd_activate,
  input logic                      o_data_in_rd_ready,
  input logic                      i_data_in_rd_activate
);

  int fail_count = 0;

  // A waiting beat stays put until it is taken
  tx_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_beat))
  else begin
    fail_count++;
    $error("tx beat dropped or changed before acceptance");
  end

  // Bank is let go right after the last beat
  rx_last_release: assert property (@(posedge i_clk) disable iff (i_reset)
    i_rx_valid && o_rx_ready && i_rx_beat.last |=> !o_rx_ready)
  else begin
    fail_count++;
    $error("rx ready stayed high after the last beat was accepted");
  end

  reset_state: assert property (@(posedge i_clk)
    i_reset |=> (o_cmd_out_wr_ready == 2'b11) && (o_data_out_wr_ready == 2'b11)
                && !o_tx_valid && !o_rx_ready)
  else begin
    fail_count++;
    $error("handshake outputs wrong during reset");
  end

  // A bank just released by the reader is not offered again at once
  cmd_rd_gap: assert property (@(posedge i_clk) disable iff (i_reset)
    $fell(i_cmd_in_rd_activate) |-> !o_cmd_in_rd_ready)
  else begin
    fail_count++;
    $error("command read ready high in the cycle the bank was released");
  end

  data_rd_gap: assert property (@(posedge i_clk) disable iff (i_reset)
    $fell(i_data_in_rd_activate) |-> !o_data_in_rd_ready)
  else begin
    fail_count++;
    $error("data read ready high in the cycle the bank was released");
  end

endmodule

bind pcie_fifo_top pcie_fifo_assert u_assert (.*);

// File: tb/tb_pcie_fifo.sv
`timescale 1ns/1ps

module tb_pcie_fifo;

  logic                              i_clk;
  logic                              i_reset;
  logic                              i_function_number;
  logic                              i_rx_valid;
  pcie_fifo_pkg::axis_beat_t         i_rx_beat;
  logic                              o_rx_ready;
  logic                              o_tx_valid;
  pcie_fifo_pkg::axis_beat_t         o_tx_beat;
  logic                              i_tx_ready;

  // Index 0 is the command channel, index 1 the data channel
  logic [1:0]                        in_rd_ready;
  logic [1:0]                        in_rd_act;
  logic [1:0]                        in_rd_stb;
  logic [pcie_fifo_pkg::COUNT_W-1:0] in_rd_count [2];
  pcie_fifo_pkg::word_t              in_rd_data [2];
  logic [1:0]                        out_wr_ready [2];
  logic [1:0]                        out_wr_act [2];
  logic [1:0]                        out_wr_stb;
  pcie_fifo_pkg::word_t              out_wr_data [2];

  // Test steps from the stimulus file
  logic [47:0]          kind_q [$];
  logic                 func_q [$];
  int                   len_q [$];
  pcie_fifo_pkg::word_t start_q [$];

  int errors = 0;
  int cycles = 0;
  int total_words = 0;
  int cycle_limit = 100000;

  pcie_fifo_top dut (
    .i_clk(i_clk), .i_reset(i_reset), .i_function_number(i_function_number),
    .i_rx_valid(i_rx_valid), .i_rx_beat(i_rx_beat), .o_rx_ready(o_rx_ready),
    .o_tx_valid(o_tx_valid), .o_tx_beat(o_tx_beat), .i_tx_ready(i_tx_ready),
    .o_cmd_in_rd_ready(in_rd_ready[0]), .i_cmd_in_rd_activate(in_rd_act[0]),
    .i_cmd_in_rd_stb(in_rd_stb[0]), .o_cmd_in_rd_count(in_rd_count[0]),
    .o_cmd_in_rd_data(in_rd_data[0]),
    .o_cmd_out_wr_ready(out_wr_ready[0]), .i_cmd_out_wr_activate(out_wr_act[0]),
    .i_cmd_out_wr_stb(out_wr_stb[0]), .i_cmd_out_wr_data(out_wr_data[0]),
    .o_data_in_rd_ready(in_rd_ready[1]), .i_data_in_rd_activate(in_rd_act[1]),
    .i_data_in_rd_stb(in_rd_stb[1]), .o_data_in_rd_count(in_rd_count[1]),
    .o_data_in_rd_data(in_rd_data[1]),
    .o_data_out_wr_ready(out_wr_ready[1]), .i_data_out_wr_activate(out_wr_act[1]),
    .i_data_out_wr_stb(out_wr_stb[1]), .i_data_out_wr_data(out_wr_data[1])
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  // Watchdog
  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("errors: %0d", errors + 1);
      $display("test failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic load_stimulus();
    int                   fd;
    int                   n;
    int                   func_v;
    int                   len;
    logic [8*80-1:0]      line;
    logic [47:0]          kind;
    pcie_fifo_pkg::word_t start;
    fd = $fopen("tb/pcie_fifo_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the stimulus file tb/pcie_fifo_stimulus.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Comment and blank lines do not give four fields
        n = $sscanf(line, "%s %d %d %h", kind, func_v, len, start);
        if (n == 4) begin
          kind_q.push_back(kind);
          func_q.push_back(func_v[0]);
          len_q.push_back(len);
          start_q.push_back(start);
          total_words += len;
        end
      end
      $fclose(fd);
    end
  endtask

  // Drain one ingress bank and compare count and words
  task automatic read_bank(input logic chan, input int cnt, input pcie_fifo_pkg::word_t start);
    @(negedge i_clk);
    while (!in_rd_ready[chan]) @(negedge i_clk);
    check_value(chan ? "o_cmd_in_rd_ready" : "o_data_in_rd_ready", 0, in_rd_ready[~chan]);
    @(posedge i_clk);
    #1;
    in_rd_act[chan] = 1'b1;
    in_rd_stb[chan] = 1'b1;
    for (int j = 0; j < cnt; j++) begin
      @(negedge i_clk);
      if (j == 0) begin
        check_value(chan ? "o_data_in_rd_count" : "o_cmd_in_rd_count", cnt, in_rd_count[chan]);
      end
      check_value(chan ? "o_data_in_rd_data" : "o_cmd_in_rd_data", start + j, in_rd_data[chan]);
      @(posedge i_clk);
      #1;
    end
    in_rd_act[chan] = 1'b0;
    in_rd_stb[chan] = 1'b0;
  endtask

  // Send one rx packet, optionally flipping the function bit halfway
  task automatic send_rx(input logic func, input int len, input pcie_fifo_pkg::word_t start,
                         input logic flip);
    int bank_words;
    int left;
    pcie_fifo_pkg::word_t value;
    bank_words = func ? (1 << pcie_fifo_pkg::DATA_ADDR_W) : (1 << pcie_fifo_pkg::CMD_ADDR_W);
    i_function_number = func;
    @(posedge i_clk);
    #1;
    for (int k = 0; k < len; k++) begin
      i_rx_valid     = 1'b1;
      i_rx_beat.data = start + k;
      i_rx_beat.last = (k == len - 1);
      if (flip && (k == len / 2)) begin
        i_function_number = ~func;
      end
      @(negedge i_clk);
      while (!o_rx_ready) @(negedge i_clk);
      @(posedge i_clk);
      #1;
    end
    i_rx_valid = 1'b0;
    // Long packets continue in the next bank
    left  = len;
    value = start;
    while (left > 0) begin
      read_bank(func, (left > bank_words) ? bank_words : left, value);
      value += (left > bank_words) ? bank_words : left;
      left  -= (left > bank_words) ? bank_words : left;
    end
  endtask

  // Fill one egress bank, then collect the tx packet under random stalls
  task automatic send_tx(input logic func, input int len, input pcie_fifo_pkg::word_t start);
    logic [1:0] bank;
    int         k;
    i_function_number = func;
    @(negedge i_clk);
    while (out_wr_ready[func] == 2'b00) @(negedge i_clk);
    bank = out_wr_ready[func][0] ? 2'b01 : 2'b10;
    @(posedge i_clk);
    #1;
    out_wr_act[func] = bank;
    out_wr_stb[func] = 1'b1;
    for (int j = 0; j < len; j++) begin
      out_wr_data[func] = start + j;
      @(posedge i_clk);
      #1;
    end
    out_wr_act[func] = 2'b00;
    out_wr_stb[func] = 1'b0;
    k = 0;
    while (k < len) begin
      @(negedge i_clk);
      if (o_tx_valid && i_tx_ready) begin
        check_value("o_tx_beat.data", start + k, o_tx_beat.data);
        check_value("o_tx_beat.last", (k == len - 1), o_tx_beat.last);
        k++;
      end
      @(posedge i_clk);
      #1;
      i_tx_ready = (($urandom % 4) != 0);
    end
    i_tx_ready = 1'b0;
    @(negedge i_clk);
    check_value("o_tx_valid", 0, o_tx_valid);
    @(posedge i_clk);
    #1;
  endtask

  initial begin
    i_reset           = 1'b1;
    i_function_number = pcie_fifo_pkg::CMD_FUNCTION_ID;
    i_rx_valid        = 1'b0;
    i_rx_beat         = '0;
    i_tx_ready        = 1'b0;
    in_rd_act         = 2'b00;
    in_rd_stb         = 2'b00;
    out_wr_act        = '{default: 2'b00};
    out_wr_stb        = 2'b00;
    out_wr_data       = '{default: '0};
    void'($urandom(32'hb32d_0b67));
    load_stimulus();
    cycle_limit = total_words * 8 + 2000;

    repeat (8) @(posedge i_clk);
    #1;
    check_value("o_cmd_out_wr_ready", 2'b11, out_wr_ready[0]);
    check_value("o_data_out_wr_ready", 2'b11, out_wr_ready[1]);
    check_value("o_cmd_in_rd_ready", 0, in_rd_ready[0]);
    check_value("o_data_in_rd_ready", 0, in_rd_ready[1]);
    check_value("o_tx_valid", 0, o_tx_valid);
    check_value("o_rx_ready", 0, o_rx_ready);
    i_reset = 1'b0;

    for (int i = 0; i < kind_q.size(); i++) begin
      if (kind_q[i] == "rx") begin
        send_rx(func_q[i], len_q[i], start_q[i], 1'b0);
      end else if (kind_q[i] == "switch") begin
        send_rx(func_q[i], len_q[i], start_q[i], 1'b1);
      end else if (kind_q[i] == "tx") begin
        send_tx(func_q[i], len_q[i], start_q[i]);
      end else begin
        errors++;
        $display("unknown step kind %s in the stimulus file", kind_q[i]);
      end
    end

    repeat (4) @(posedge i_clk);
    errors += dut.u_assert.fail_count;
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: tb/pcie_fifo_stimulus.txt
# kind function length start
# kind is rx, tx or switch and the start value is hex
rx     0 1   00000100
rx     0 8   10000000
rx     0 32  20000000
rx     1 16  30000000
rx     0 40  40000000
rx     1 100 50000000
rx     1 128 51000000
tx     0 1   60000000
tx     0 12  61000000
tx     0 32  62000000
tx     1 20  70000000
tx     1 128 71000000
switch 0 10  80000000
rx     1 6   81000000
switch 1 24  90000000
rx     0 5   91000000
rx     1 130 a0000000
tx     0 7   b0000000
rx     0 64  c0000000
tx     1 3   d0000000

// File: all.f
common/pcie_fifo_pkg.sv
ppfifo/ppfifo.sv
verilog/axis_to_ppfifo.sv
verilog/ppfifo_to_axis.sv
verilog/function_steer.sv
verilog/pcie_fifo_top.sv
tb/pcie_fifo_assert.sv
tb/tb_pcie_fifo.sv

// File: Bender.yml
package:
  name: pcie_fifo

sources:
  - common/pcie_fifo_pkg.sv
  - ppfifo/ppfifo.sv
  - verilog/axis_to_ppfifo.sv
  - verilog/ppfifo_to_axis.sv
  - verilog/function_steer.sv
  - verilog/pcie_fifo_top.sv
  - target: test
    files:
      - tb/pcie_fifo_assert.sv
      - tb/tb_pcie_fifo.sv
